// ==== design/lsu_issue.sv ====
/* request gating by interrupt, steering to load and store paths, stall merge */
module lsu_issue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_i,
    input  logic              int_assert_i,
    input  lsu_pkg::lsu_req_t req_data_i,
    input  logic              ld_stall_i,
    input  logic              st_stall_i,
    output lsu_pkg::lsu_req_t ld_req_o,
    output lsu_pkg::lsu_req_t st_req_o,
    output logic              mem_stall_o
);

    logic req_valid;

    // an interrupt drops the request of this cycle
    assign req_valid = req_i & ~int_assert_i;

    always_comb begin
        ld_req_o          = req_data_i;
        ld_req_o.is_load  = req_valid & req_data_i.is_load;
        ld_req_o.is_store = 1'b0;
        st_req_o          = req_data_i;
        st_req_o.is_load  = 1'b0;
        st_req_o.is_store = req_valid & req_data_i.is_store;
    end

    assign mem_stall_o = ld_stall_i | st_stall_i;

    // the execute stage never asks for both at once
    a_single_op: assert property (@(posedge clk) disable iff (!rst_n)
        req_i |-> !(req_data_i.is_load && req_data_i.is_store));

    // a stalled request is held unchanged until it is taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && mem_stall_o) |=> (req_i && $stable(req_data_i)));

endmodule

// ==== design/lsu_load_align.sv ====
/* byte and halfword selection, sign/zero extension, registered write-back */
`include "lsu_macros.svh"

module lsu_load_align (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rsp_valid_i,
    input  lsu_pkg::lsu_ld_tag_t rsp_tag_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    output lsu_pkg::lsu_wb_t     wb_o
);
    import lsu_pkg::*;

    lsu_rdata_u                  rdata;
    logic [7:0]                  sel_byte;
    logic [15:0]                 sel_half;
    logic [`LSU_XLEN-1:0]        ext_data;
    logic                        we_q;
    logic [`LSU_REG_ADDR_W-1:0]  rd_q;
    logic [`LSU_XLEN-1:0]        data_q;
    logic [`LSU_COMMIT_ID_W-1:0] commit_id_q;

    assign rdata = rdata_i;

    // lane picked by the low address bits
    assign sel_byte = rdata.b[rsp_tag_i.addr_lo];
    assign sel_half = rdata.h[rsp_tag_i.addr_lo[1]];

    always_comb begin
        case (rsp_tag_i.funct3)
            `LSU_F3_LB:  ext_data = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};
            `LSU_F3_LBU: ext_data = {{(`LSU_XLEN-8){1'b0}}, sel_byte};
            `LSU_F3_LH:  ext_data = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};
            `LSU_F3_LHU: ext_data = {{(`LSU_XLEN-16){1'b0}}, sel_half};
            // LW and anything unexpected pass the whole word
            default:     ext_data = rdata_i;
        endcase
    end

    // write enable follows each R beat by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid_i) begin
            rd_q        <= rsp_tag_i.rd;
            data_q      <= ext_data;
            commit_id_q <= rsp_tag_i.commit_id;
        end
    end

    assign wb_o = '{
        we:        we_q,
        rd:        rd_q,
        data:      data_q,
        commit_id: commit_id_q
    };

endmodule

// ==== design/lsu_load_tracker.sv ====
/* AR issue and in-order queue of outstanding load tags,
   with bypass when read data returns in the address cycle */
`include "lsu_macros.svh"

module lsu_load_tracker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lsu_pkg::lsu_req_t    ld_req_i,
    input  logic                 arready_i,
    input  logic                 rvalid_i,
    output logic                 ld_stall_o,
    output logic                 arvalid_o,
    output logic [`LSU_XLEN-1:0] araddr_o,
    output logic                 rready_o,
    output logic                 rsp_valid_o,
    output lsu_pkg::lsu_ld_tag_t rsp_tag_o
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    lsu_ld_tag_t      tag_q [DEPTH];
    lsu_ld_tag_t      new_tag;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             empty;
    logic             full;
    logic             ar_fire;
    logic             r_fire;
    logic             bypass;
    logic             push;
    logic             pop;

    assign new_tag = '{
        funct3:    ld_req_i.funct3,
        rd:        ld_req_i.rd,
        addr_lo:   ld_req_i.addr[1:0],
        commit_id: ld_req_i.commit_id
    };

    assign empty = (count == '0);
    assign full  = (count == DEPTH[PTR_W:0]);

    // no new address while every tag slot is taken
    assign arvalid_o  = ld_req_i.is_load & ~full;
    assign araddr_o   = ld_req_i.addr;
    assign ld_stall_o = ld_req_i.is_load & (full | ~arready_i);
    assign rready_o   = 1'b1;

    assign ar_fire = arvalid_o & arready_i;
    assign r_fire  = rvalid_i & rready_o;

    // data for the very load being issued, nothing older pending
    assign bypass = ar_fire & empty & r_fire;
    assign push   = ar_fire & ~bypass;
    assign pop    = r_fire & ~empty;

    assign rsp_valid_o = r_fire & (bypass | ~empty);
    assign rsp_tag_o   = empty ? new_tag : tag_q[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_q[wr_ptr] <= new_tag;
        end
    end

    // the memory side only answers loads it has accepted
    a_r_has_owner: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i |-> (!empty || bypass));

endmodule

// ==== design/lsu_macros.svh ====
/* width, queue depth and funct3 macros for the load/store unit */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// register file index width
`define LSU_REG_ADDR_W 5

// commit tag width from the issue logic
`define LSU_COMMIT_ID_W 3

// entries in the load tag queue and in the store data queue
`define LSU_QUEUE_DEPTH 4

// load funct3 encodings
`define LSU_F3_LB 3'd0
`define LSU_F3_LH 3'd1
`define LSU_F3_LW 3'd2
`define LSU_F3_LBU 3'd4
`define LSU_F3_LHU 3'd5

`endif

// ==== design/lsu_pkg.sv ====
/* load/store unit types: request, load tag, store beat,
   register write-back and the read-data word views */
`include "lsu_macros.svh"

package lsu_pkg;

    // request as presented by the execute stage
    typedef struct packed {
        logic                        is_load;
        logic                        is_store;
        logic [2:0]                  funct3;
        logic [`LSU_REG_ADDR_W-1:0]  rd;
        logic [`LSU_XLEN-1:0]        addr;
        logic [`LSU_XLEN-1:0]        wdata;
        logic [`LSU_XLEN/8-1:0]      wmask;
        logic [`LSU_COMMIT_ID_W-1:0] commit_id;
    } lsu_req_t;

    // context kept per outstanding load
    typedef struct packed {
        logic [2:0]                  funct3;
        logic [`LSU_REG_ADDR_W-1:0]  rd;
        logic [1:0]                  addr_lo;
        logic [`LSU_COMMIT_ID_W-1:0] commit_id;
    } lsu_ld_tag_t;

    // one W channel beat
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   data;
        logic [`LSU_XLEN/8-1:0] strb;
    } lsu_st_beat_t;

    typedef struct packed {
        logic                        we;
        logic [`LSU_REG_ADDR_W-1:0]  rd;
        logic [`LSU_XLEN-1:0]        data;
        logic [`LSU_COMMIT_ID_W-1:0] commit_id;
    } lsu_wb_t;

    // read data seen as bytes or as halfwords
    typedef union packed {
        logic [`LSU_XLEN/8-1:0][7:0]   b;
        logic [`LSU_XLEN/16-1:0][15:0] h;
    } lsu_rdata_u;

endpackage

// ==== design/lsu_store_buffer.sv ====
/* AW issue, store data queue for a lagging W channel, W drive and busy flag */
`include "lsu_macros.svh"

module lsu_store_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_pkg::lsu_req_t      st_req_i,
    input  logic                   awready_i,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    output logic                   st_stall_o,
    output logic                   awvalid_o,
    output logic [`LSU_XLEN-1:0]   awaddr_o,
    output logic                   wvalid_o,
    output logic [`LSU_XLEN-1:0]   wdata_o,
    output logic [`LSU_XLEN/8-1:0] wstrb_o,
    output logic                   bready_o,
    output logic                   mem_busy_o
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    lsu_st_beat_t     beat_q [DEPTH];
    lsu_st_beat_t     new_beat;
    lsu_st_beat_t     w_beat;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [7:0]       b_outstanding;
    logic             empty;
    logic             full;
    logic             aw_fire;
    logic             push;
    logic             pop;

    assign new_beat = '{data: st_req_i.wdata, strb: st_req_i.wmask};

    assign empty = (count == '0);
    assign full  = (count == DEPTH[PTR_W:0]);

    assign awvalid_o  = st_req_i.is_store & ~full;
    assign awaddr_o   = st_req_i.addr;
    assign st_stall_o = st_req_i.is_store & (full | ~awready_i);
    assign aw_fire    = awvalid_o & awready_i;

    // the new store only goes on W together with its address,
    // so a stalled store never sends its data twice
    assign wvalid_o = ~empty | aw_fire;
    assign w_beat   = empty ? new_beat : beat_q[rd_ptr];
    assign wdata_o  = w_beat.data;
    assign wstrb_o  = w_beat.strb;

    // queue behind older data to keep W in AW order
    assign push = aw_fire & (~wready_i | ~empty);
    assign pop  = ~empty & wready_i;

    assign mem_busy_o = ~empty;
    assign bready_o   = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            beat_q[wr_ptr] <= new_beat;
        end
    end

    // writes still waiting for a response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_outstanding <= '0;
        end else begin
            b_outstanding <= b_outstanding + {7'd0, aw_fire} - {7'd0, bvalid_i & bready_o};
        end
    end

    // pointers and count agree and stay within the queue depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (count <= DEPTH[PTR_W:0]) && (wr_ptr - rd_ptr == count[PTR_W-1:0]));

    a_b_has_owner: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i |-> (b_outstanding != '0));

endmodule

// ==== design/lsu_top.sv ====
/* load/store unit top: issue stage, load tracker, load align, store buffer */
`include "lsu_macros.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_i,
    input  logic                   int_assert_i,
    input  lsu_pkg::lsu_req_t      req_data_i,
    output logic                   mem_stall_o,
    output logic                   mem_busy_o,
    output lsu_pkg::lsu_wb_t       wb_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    output logic [`LSU_XLEN-1:0]   araddr_o,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    input  logic [`LSU_XLEN-1:0]   rdata_i,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output logic [`LSU_XLEN-1:0]   awaddr_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    output logic [`LSU_XLEN-1:0]   wdata_o,
    output logic [`LSU_XLEN/8-1:0] wstrb_o,
    input  logic                   bvalid_i,
    output logic                   bready_o
);
    import lsu_pkg::*;

    lsu_req_t    ld_req;
    lsu_req_t    st_req;
    logic        ld_stall;
    logic        st_stall;
    logic        rsp_valid;
    lsu_ld_tag_t rsp_tag;

    lsu_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .req_data_i   (req_data_i),
        .ld_stall_i   (ld_stall),
        .st_stall_i   (st_stall),
        .ld_req_o     (ld_req),
        .st_req_o     (st_req),
        .mem_stall_o  (mem_stall_o)
    );

    lsu_load_tracker u_load_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld_req_i    (ld_req),
        .arready_i   (arready_i),
        .rvalid_i    (rvalid_i),
        .ld_stall_o  (ld_stall),
        .arvalid_o   (arvalid_o),
        .araddr_o    (araddr_o),
        .rready_o    (rready_o),
        .rsp_valid_o (rsp_valid),
        .rsp_tag_o   (rsp_tag)
    );

    lsu_load_align u_load_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp_valid_i (rsp_valid),
        .rsp_tag_i   (rsp_tag),
        .rdata_i     (rdata_i),
        .wb_o        (wb_o)
    );

    lsu_store_buffer u_store_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_req_i   (st_req),
        .awready_i  (awready_i),
        .wready_i   (wready_i),
        .bvalid_i   (bvalid_i),
        .st_stall_o (st_stall),
        .awvalid_o  (awvalid_o),
        .awaddr_o   (awaddr_o),
        .wvalid_o   (wvalid_o),
        .wdata_o    (wdata_o),
        .wstrb_o    (wstrb_o),
        .bready_o   (bready_o),
        .mem_busy_o (mem_busy_o)
    );

endmodule

// ==== dv/tb_axi_mem.sv ====
/* AXI slave byte memory with random ready/valid delays and in-order reads */
module tb_axi_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_ar_i,
    input  logic        hold_aw_i,
    input  logic        hold_w_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [31:0] araddr_i,
    output logic        rvalid_o,
    output logic [31:0] rdata_o,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    output logic        bvalid_o,
    output logic        idle_o
);
    timeunit 1ns;
    timeprecision 100ps;

    integer      seed = 43;
    logic [7:0]  mem [logic [31:0]];
    logic [31:0] ar_q [$];
    logic [31:0] aw_q [$];
    logic [35:0] w_q [$];

    // untouched bytes read back a pattern of the whole address
    function automatic logic [7:0] rd_byte(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    assign idle_o = (aw_q.size() == 0) && (w_q.size() == 0);

    always @(posedge clk or negedge rst_n) begin
        logic [31:0] a;
        logic [35:0] beat;
        logic        wrote;
        if (!rst_n) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            rdata_o   <= '0;
        end else begin
            wrote = 1'b0;
            if (rvalid_o) void'(ar_q.pop_front());
            if (arvalid_i && arready_o) ar_q.push_back(araddr_i);
            if (awvalid_i && awready_o) aw_q.push_back(awaddr_i);
            if (wvalid_i && wready_o) w_q.push_back({wstrb_i, wdata_i});
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                a = aw_q.pop_front() & ~32'd3;
                beat = w_q.pop_front();
                for (int i = 0; i < 4; i++) begin
                    if (beat[32+i]) mem[a+i] = beat[8*i+:8];
                end
                wrote = 1'b1;
            end
            bvalid_o  <= wrote;
            arready_o <= !hold_ar_i && (($random(seed) & 3) != 0);
            awready_o <= !hold_aw_i && (($random(seed) & 3) != 0);
            wready_o  <= !hold_w_i && (($random(seed) & 3) != 0);
            rvalid_o  <= 1'b0;
            if (ar_q.size() > 0 && (($random(seed) & 3) != 0)) begin
                a = ar_q[0] & ~32'd3;
                rvalid_o <= 1'b1;
                rdata_o  <= {rd_byte(a+3), rd_byte(a+2), rd_byte(a+1), rd_byte(a)};
            end
        end
    end
endmodule

// ==== dv/tb_clk_gen.sv ====
/* clock and reset generator for the testbench */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for 16 cycles, released away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end
endmodule

// ==== dv/tb_lsu.sv ====
/* load/store unit testbench: test table, driver, byte image, write-back checker,
   watchdog and report */
`include "lsu_macros.svh"

module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    typedef enum int {BP_NONE, BP_AR, BP_AW, BP_W} bp_e;
    typedef struct {
        string       name;
        bit          store;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [4:0]  rd;
        logic [2:0]  cid;
        bit          intr;
        bp_e         bp;
    } entry_t;
    typedef struct {
        string       name;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [2:0]  cid;
    } exp_t;

    logic clk, rst_n, req_i, int_assert_i, mem_stall_o, mem_busy_o;
    logic hold_ar, hold_aw, hold_w, mem_idle;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready;
    logic bvalid, bready;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [3:0]  wstrb;
    lsu_req_t    req_data_i;
    lsu_wb_t     wb_o;
    entry_t      tbl [$];
    exp_t        exp_q [$];
    logic [7:0]  image [logic [31:0]];
    int          errors = 0;
    int          failed = 0;
    int          done = 0;

    tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    lsu_top dut (.clk, .rst_n, .req_i, .int_assert_i, .req_data_i, .mem_stall_o,
        .mem_busy_o, .wb_o, .arvalid_o(arvalid), .arready_i(arready),
        .araddr_o(araddr), .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata),
        .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .bvalid_i(bvalid), .bready_o(bready));

    tb_axi_mem u_mem (.clk, .rst_n, .hold_ar_i(hold_ar), .hold_aw_i(hold_aw),
        .hold_w_i(hold_w), .arvalid_i(arvalid), .arready_o(arready),
        .araddr_i(araddr), .rvalid_o(rvalid), .rdata_o(rdata),
        .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .bvalid_o(bvalid), .idle_o(mem_idle));

    task automatic add(input string n, input bit st, input logic [2:0] f3,
                       input logic [31:0] a, input logic [31:0] d, input logic [3:0] m,
                       input logic [4:0] rd, input logic [2:0] cid, input bit intr,
                       input bp_e bp);
        tbl.push_back('{n, st, f3, a, d, m, rd, cid, intr, bp});
    endtask

    function automatic logic [7:0] img(input logic [31:0] a);
        if (image.exists(a)) return image[a];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    // expected register value from RISC-V load rules, little endian
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = img(a);
        h = {img((a & ~32'd1) + 1), img(a & ~32'd1)};
        case (f3)
            `LSU_F3_LB:  return {{24{b[7]}}, b};
            `LSU_F3_LBU: return {24'd0, b};
            `LSU_F3_LH:  return {{16{h[15]}}, h};
            `LSU_F3_LHU: return {16'd0, h};
            default: return {img((a & ~32'd3) + 3), img((a & ~32'd3) + 2),
                             img((a & ~32'd3) + 1), img(a & ~32'd3)};
        endcase
    endfunction

    // write-back checker, results must come back in request order
    always @(negedge clk) begin
        exp_t  e;
        string exp_s;
        string got_s;
        if (rst_n) begin
            assert (rready && bready) else begin
                $display("rready or bready went low");
                errors++;
            end
        end
        if (rst_n && wb_o.we) begin
            assert (exp_q.size() > 0) else begin
                $display("write-back seen with no load outstanding");
                errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                exp_s = $sformatf("rd %0d data %h cid %0d", e.rd, e.data, e.cid);
                got_s = $sformatf("rd %0d data %h cid %0d", wb_o.rd, wb_o.data,
                                  wb_o.commit_id);
                assert (wb_o.data == e.data && wb_o.rd == e.rd && wb_o.commit_id == e.cid)
                else begin
                    $display("Mismatch %s: expected %s, got %s", e.name, exp_s, got_s);
                    errors++;
                    failed++;
                end
                $display("test %s finished", e.name);
                done++;
            end
        end
    end

    // limit of 50 cycles per table entry
    initial begin
        wait (rst_n);
        repeat (tbl.size() * 50) @(posedge clk);
        $display("watchdog expired, the run did not finish");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int n;
        int err0;
        req_i = 1'b0;
        int_assert_i = 1'b0;
        req_data_i = '0;
        hold_ar = 1'b0;
        hold_aw = 1'b0;
        hold_w = 1'b0;
        add("sw_word", 1, 3'd2, 32'h100, 32'hdeadbeef, 4'hf, 0, 0, 0, BP_NONE);
        add("lw_word", 0, `LSU_F3_LW, 32'h100, 0, 0, 5, 1, 0, BP_NONE);
        add("sb_lane1", 1, 3'd0, 32'h105, 32'h00008000, 4'h2, 0, 0, 0, BP_NONE);
        add("sh_upper", 1, 3'd1, 32'h106, 32'hff7f0000, 4'hc, 0, 0, 0, BP_NONE);
        add("sb_lane0", 1, 3'd0, 32'h104, 32'h00000081, 4'h1, 0, 0, 0, BP_NONE);
        add("lb_off0", 0, `LSU_F3_LB, 32'h104, 0, 0, 1, 2, 0, BP_NONE);
        add("lb_off1", 0, `LSU_F3_LB, 32'h105, 0, 0, 2, 3, 0, BP_NONE);
        add("lb_off2", 0, `LSU_F3_LB, 32'h106, 0, 0, 15, 4, 0, BP_NONE);
        add("lb_off3", 0, `LSU_F3_LB, 32'h107, 0, 0, 16, 5, 0, BP_NONE);
        add("lbu_off0", 0, `LSU_F3_LBU, 32'h104, 0, 0, 17, 6, 0, BP_NONE);
        add("lbu_off1", 0, `LSU_F3_LBU, 32'h105, 0, 0, 18, 7, 0, BP_NONE);
        add("lbu_off2", 0, `LSU_F3_LBU, 32'h106, 0, 0, 3, 4, 0, BP_NONE);
        add("lbu_off3", 0, `LSU_F3_LBU, 32'h107, 0, 0, 4, 5, 0, BP_NONE);
        add("lh_off0", 0, `LSU_F3_LH, 32'h104, 0, 0, 6, 6, 0, BP_NONE);
        add("lh_off2", 0, `LSU_F3_LH, 32'h106, 0, 0, 7, 7, 0, BP_NONE);
        add("lhu_off0", 0, `LSU_F3_LHU, 32'h104, 0, 0, 19, 1, 0, BP_NONE);
        add("lhu_off2", 0, `LSU_F3_LHU, 32'h106, 0, 0, 8, 0, 0, BP_NONE);
        add("lhu_fill", 0, `LSU_F3_LHU, 32'h202, 0, 0, 9, 1, 0, BP_NONE);
        add("sw_aw_held", 1, 3'd2, 32'h108, 32'h0badf00d, 4'hf, 0, 0, 0, BP_AW);
        add("lw_ar_held", 0, `LSU_F3_LW, 32'h108, 0, 0, 10, 2, 0, BP_AR);
        add("sw_irq", 1, 3'd2, 32'h100, 32'h0, 4'hf, 0, 0, 1, BP_NONE);
        add("lw_irq", 0, `LSU_F3_LW, 32'h100, 0, 0, 11, 3, 1, BP_NONE);
        add("lw_after_irq", 0, `LSU_F3_LW, 32'h100, 0, 0, 12, 4, 0, BP_NONE);
        add("sw_w_held0", 1, 3'd2, 32'h110, 32'h11111111, 4'hf, 0, 0, 0, BP_W);
        add("sw_w_held1", 1, 3'd2, 32'h114, 32'h22222222, 4'hf, 0, 0, 0, BP_W);
        add("sb_w_held2", 1, 3'd0, 32'h112, 32'h00330000, 4'h4, 0, 0, 0, BP_W);
        add("lw_drain0", 0, `LSU_F3_LW, 32'h110, 0, 0, 13, 5, 0, BP_NONE);
        add("lw_drain1", 0, `LSU_F3_LW, 32'h114, 0, 0, 14, 6, 0, BP_NONE);
        wait (rst_n);
        @(negedge clk);
        foreach (tbl[i]) begin
            err0 = errors;
            if (!tbl[i].store && !tbl[i].intr) begin
                // loads see memory only after every store has landed
                hold_w = 1'b0;
                while (mem_busy_o || !mem_idle) @(negedge clk);
            end
            hold_ar = (tbl[i].bp == BP_AR);
            hold_aw = (tbl[i].bp == BP_AW);
            if (tbl[i].bp == BP_W) hold_w = 1'b1;
            // back-pressure reaches the memory ready flops one edge later
            if (tbl[i].bp != BP_NONE) @(negedge clk);
            req_i = 1'b1;
            int_assert_i = tbl[i].intr;
            req_data_i = '{!tbl[i].store, tbl[i].store, tbl[i].f3, tbl[i].rd,
                           tbl[i].addr, tbl[i].data, tbl[i].mask, tbl[i].cid};
            if (tbl[i].intr) begin
                #1;
                assert (!mem_stall_o && !arvalid && !awvalid) else begin
                    $display("request under interrupt raised a stall or an AXI valid");
                    errors++;
                end
                @(negedge clk);
            end else begin
                n = 0;
                #1;
                while (mem_stall_o) begin
                    n++;
                    // ready returns after four stalled cycles
                    if (n == 4) begin
                        hold_ar = 1'b0;
                        hold_aw = 1'b0;
                    end
                    @(negedge clk);
                    #1;
                end
                @(posedge clk);
                assert (tbl[i].bp inside {BP_NONE, BP_W} || n >= 4) else begin
                    $display("%s was taken while ready was held low", tbl[i].name);
                    errors++;
                end
                if (tbl[i].store) begin
                    for (int k = 0; k < 4; k++) begin
                        if (tbl[i].mask[k])
                            image[(tbl[i].addr & ~32'd3) + k] = tbl[i].data[8*k+:8];
                    end
                end else begin
                    exp_q.push_back('{tbl[i].name, tbl[i].rd,
                                      load_value(tbl[i].f3, tbl[i].addr), tbl[i].cid});
                end
                @(negedge clk);
                if (tbl[i].bp == BP_W) begin
                    assert (mem_busy_o) else begin
                        $display("%s left the store buffer empty while W was held", tbl[i].name);
                        errors++;
                    end
                end
            end
            req_i = 1'b0;
            int_assert_i = 1'b0;
            if (tbl[i].store || tbl[i].intr) begin
                if (errors != err0) failed++;
                $display("test %s finished", tbl[i].name);
                done++;
            end
        end
        hold_w = 1'b0;
        while (exp_q.size() > 0 || mem_busy_o) @(negedge clk);
        repeat (10) @(negedge clk);
        $display("tests run %0d, failed %0d, errors %0d", done, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

// ==== lsu.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu_issue.sv
design/lsu_load_tracker.sv
design/lsu_load_align.sv
design/lsu_store_buffer.sv
design/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_axi_mem.sv
dv/tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f lsu.f --top-module tb_lsu \
    -o sim_lsu
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
